// File: verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [15:0] half_t;

    // instruction classes that steer the PC
    typedef enum logic [1:0] {
        R_TYPE,
        B_TYPE,
        J_TYPE
    } encoding_t;

    typedef enum logic {
        PRED_STATIC_NT,
        PRED_DYNAMIC
    } pred_mode_t;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // program end marker, fetch wraps back to address zero
    localparam instr_t END_INSTR = 32'h0000_1111;

endpackage

`default_nettype wire

// File: verilog/instr_decompressor.sv
`default_nettype none

module instr_decompressor import fetch_pkg::*; (
    input  half_t  c_parcel,
    input  logic   is_compressed,
    output instr_t decompressed_instr,
    output logic   decompress_failed
);

    logic [1:0]  quadrant;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rd_p;
    logic [4:0]  rs1_p;
    logic [11:0] imm6_sx;
    logic [11:0] addi4spn_imm;
    logic [11:0] lw_imm;
    logic [11:0] lwsp_imm;
    logic [11:0] addi16sp_imm;
    logic [19:0] cj_field;
    logic [6:0]  cb_hi;
    logic [4:0]  cb_lo;
    logic [2:0]  alu_f3;
    instr_t      expanded;
    logic        illegal;

    assign quadrant = c_parcel[1:0];
    assign funct3   = c_parcel[15:13];
    assign rd       = c_parcel[11:7];
    assign rs2      = c_parcel[6:2];
    // three-bit register fields map onto x8..x15
    assign rd_p     = {2'b01, c_parcel[4:2]};
    assign rs1_p    = {2'b01, c_parcel[9:7]};

    assign imm6_sx      = {{6{c_parcel[12]}}, c_parcel[12], c_parcel[6:2]};
    assign addi4spn_imm = {2'b00, c_parcel[10:7], c_parcel[12:11], c_parcel[5], c_parcel[6],
                           2'b00};
    assign lw_imm       = {5'b0, c_parcel[5], c_parcel[12:10], c_parcel[6], 2'b00};
    assign lwsp_imm     = {4'b0, c_parcel[3:2], c_parcel[12], c_parcel[6:4], 2'b00};
    assign addi16sp_imm = {{3{c_parcel[12]}}, c_parcel[4:3], c_parcel[5], c_parcel[2],
                           c_parcel[6], 4'b0};

    // jal immediate field, already in instruction bit order
    assign cj_field = {c_parcel[12], c_parcel[8], c_parcel[10:9], c_parcel[6], c_parcel[7],
                       c_parcel[2], c_parcel[11], c_parcel[5:3], c_parcel[12],
                       {8{c_parcel[12]}}};
    assign cb_hi    = {{4{c_parcel[12]}}, c_parcel[6:5], c_parcel[2]};
    assign cb_lo    = {c_parcel[11:10], c_parcel[4:3], c_parcel[12]};

    always_comb begin
        case (c_parcel[6:5])
            2'b00:   alu_f3 = 3'b000;
            2'b01:   alu_f3 = 3'b100;
            2'b10:   alu_f3 = 3'b110;
            default: alu_f3 = 3'b111;
        endcase
    end

    always_comb begin
        expanded = '0;
        illegal  = 1'b0;
        case ({quadrant, funct3})
            // c.addi4spn, zero immediate covers the all-zero parcel
            5'b00_000: begin
                expanded = {addi4spn_imm, 5'd2, 3'b000, rd_p, OPC_OP_IMM};
                illegal  = (addi4spn_imm == '0);
            end
            5'b00_010: expanded = {lw_imm, rs1_p, 3'b010, rd_p, OPC_LOAD};
            5'b00_110: expanded = {lw_imm[11:5], rd_p, rs1_p, 3'b010, lw_imm[4:0], OPC_STORE};
            5'b01_000: expanded = {imm6_sx, rd, 3'b000, rd, OPC_OP_IMM};
            5'b01_001: expanded = {cj_field, 5'd1, OPC_JAL};
            5'b01_010: expanded = {imm6_sx, 5'd0, 3'b000, rd, OPC_OP_IMM};
            5'b01_011: begin
                if (rd == 5'd2) begin
                    expanded = {addi16sp_imm, 5'd2, 3'b000, 5'd2, OPC_OP_IMM};
                end else begin
                    expanded = {{14{c_parcel[12]}}, c_parcel[12], c_parcel[6:2], rd, OPC_LUI};
                end
                illegal = ({c_parcel[12], c_parcel[6:2]} == '0);
            end
            5'b01_100: begin
                case (c_parcel[11:10])
                    2'b00: begin
                        expanded = {7'b0, rs2, rs1_p, 3'b101, rs1_p, OPC_OP_IMM};
                        illegal  = c_parcel[12];
                    end
                    2'b01: begin
                        expanded = {7'b0100000, rs2, rs1_p, 3'b101, rs1_p, OPC_OP_IMM};
                        illegal  = c_parcel[12];
                    end
                    2'b10: expanded = {imm6_sx, rs1_p, 3'b111, rs1_p, OPC_OP_IMM};
                    default: begin
                        // sub/xor/or/and, the c[12] half is RV64 only
                        expanded = {(c_parcel[6:5] == 2'b00) ? 7'b0100000 : 7'b0, rd_p, rs1_p,
                                    alu_f3, rs1_p, OPC_OP};
                        illegal  = c_parcel[12];
                    end
                endcase
            end
            5'b01_101: expanded = {cj_field, 5'd0, OPC_JAL};
            5'b01_110,
            5'b01_111: expanded = {cb_hi, 5'd0, rs1_p, 2'b00, funct3[0], cb_lo, OPC_BRANCH};
            5'b10_000: begin
                expanded = {7'b0, rs2, rd, 3'b001, rd, OPC_OP_IMM};
                illegal  = c_parcel[12];
            end
            5'b10_010: begin
                expanded = {lwsp_imm, 5'd2, 3'b010, rd, OPC_LOAD};
                illegal  = (rd == 5'd0);
            end
            5'b10_100: begin
                if (!c_parcel[12]) begin
                    if (rs2 == 5'd0) begin
                        expanded = {12'b0, rd, 3'b000, 5'd0, OPC_JALR};
                        illegal  = (rd == 5'd0);
                    end else begin
                        expanded = {7'b0, rs2, 5'd0, 3'b000, rd, OPC_OP};
                    end
                end else if (rs2 == 5'd0) begin
                    if (rd == 5'd0) begin
                        expanded = {12'd1, 5'd0, 3'b000, 5'd0, OPC_SYSTEM};
                    end else begin
                        expanded = {12'b0, rd, 3'b000, 5'd1, OPC_JALR};
                    end
                end else begin
                    expanded = {7'b0, rs2, rd, 3'b000, rd, OPC_OP};
                end
            end
            5'b10_110: expanded = {4'b0, c_parcel[8:7], c_parcel[12], rs2, 5'd2, 3'b010,
                                   c_parcel[11:9], 2'b00, OPC_STORE};
            // floating point forms and the 32-bit quadrant
            default: illegal = 1'b1;
        endcase
    end

    assign decompressed_instr = (is_compressed && !illegal) ? expanded : '0;
    assign decompress_failed  = is_compressed && illegal;

endmodule

`default_nettype wire

// File: verilog/fetch_stage.sv
`default_nettype none

module fetch_stage import fetch_pkg::*; #(
    parameter addr_t RESET_PC = '0
) (
    input  logic   clk,
    input  logic   reset_n,
    input  instr_t data,
    input  logic   pc_write,
    input  logic   pc_src,
    input  logic   jalr_flag,
    input  addr_t  jalr_target,
    input  logic   predict_taken,
    input  instr_t decompressed_instr,
    input  logic   decompress_failed_in,
    output addr_t  address,
    output instr_t instruction_out,
    output logic   if_id_flush,
    output logic   id_ex_flush,
    output addr_t  lookup_pc,
    output logic   update_valid,
    output addr_t  update_pc,
    output logic   update_taken,
    output half_t  c_parcel,
    output logic   is_compressed,
    output logic   decompress_failed
);

    // addi x0, x0, 0 while the upper half of a split word is awaited
    localparam instr_t NOP = {25'b0, OPC_OP_IMM};

    typedef enum logic {DIRECT, USE_BUFFER} state_t;

    state_t    state;
    state_t    state_next;
    addr_t     pc_reg;
    addr_t     pc_next;
    half_t     instr_buffer;
    instr_t    raw_instr;
    instr_t    instr;
    logic      instr_valid;
    logic      fetch_ok;
    encoding_t instr_type;
    addr_t     b_imm;
    addr_t     j_imm;
    addr_t     pc_seq;
    addr_t     br_target;
    logic      take_branch;
    logic      mispredict;
    logic      fix_taken;
    logic      fix_not_taken;

    // slot 1 holds the branch being resolved this cycle
    logic      br_valid [2];
    logic      br_pred  [2];
    addr_t     br_pc    [2];
    addr_t     br_alt   [2];

    always_comb begin
        c_parcel      = pc_reg[1] ? data[31:16] : data[15:0];
        is_compressed = 1'b0;
        instr_valid   = 1'b1;
        raw_instr     = data;
        if (state == USE_BUFFER) begin
            raw_instr = {data[15:0], instr_buffer};
        end else if (c_parcel[1:0] != 2'b11) begin
            is_compressed = 1'b1;
            raw_instr     = {16'b0, c_parcel};
        end else if (pc_reg[1]) begin
            // 32-bit instruction split across words
            instr_valid = 1'b0;
        end
    end

    assign instr = !instr_valid ? NOP : (is_compressed ? decompressed_instr : raw_instr);

    always_comb begin
        case (instr[6:0])
            OPC_BRANCH: instr_type = B_TYPE;
            OPC_JAL:    instr_type = J_TYPE;
            default:    instr_type = R_TYPE;
        endcase
    end

    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign pc_seq    = pc_reg + (is_compressed ? 32'd2 : 32'd4);
    assign br_target = pc_reg + b_imm;

    // resolution of the branch fetched two cycles back
    assign mispredict    = br_valid[1] && (pc_src != br_pred[1]);
    assign fix_taken     = mispredict && pc_src;
    assign fix_not_taken = mispredict && !pc_src;
    assign if_id_flush   = mispredict || jalr_flag;
    assign id_ex_flush   = fix_taken || fix_not_taken || jalr_flag;

    // the word fetched during a flush is on the wrong path
    assign fetch_ok    = instr_valid && !if_id_flush;
    assign take_branch = fetch_ok && (instr_type == B_TYPE) && predict_taken;

    always_comb begin
        if (fix_taken) begin
            pc_next = br_alt[1];
        end else if (take_branch) begin
            pc_next = br_target;
        end else if (fetch_ok && instr_type == J_TYPE) begin
            pc_next = pc_reg + j_imm;
        end else if (jalr_flag) begin
            pc_next = jalr_target;
        end else if (fix_not_taken) begin
            pc_next = br_alt[1];
        end else if (instr_valid && raw_instr == END_INSTR) begin
            pc_next = '0;
        end else if (instr_valid) begin
            pc_next = pc_seq;
        end else begin
            pc_next = pc_reg;
        end
    end

    always_comb begin
        state_next = state;
        if (if_id_flush || state == USE_BUFFER) begin
            state_next = DIRECT;
        end else if (!instr_valid) begin
            state_next = USE_BUFFER;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_reg      <= RESET_PC;
            state       <= DIRECT;
            br_valid[0] <= 1'b0;
            br_valid[1] <= 1'b0;
            br_pred[0]  <= 1'b0;
            br_pred[1]  <= 1'b0;
        end else if (pc_write) begin
            pc_reg      <= pc_next;
            state       <= state_next;
            br_valid[0] <= fetch_ok && (instr_type == B_TYPE);
            br_valid[1] <= br_valid[0] && !if_id_flush;
            br_pred[0]  <= predict_taken;
            br_pred[1]  <= br_pred[0];
        end
    end

    always_ff @(posedge clk) begin
        if (pc_write) begin
            if (!instr_valid) begin
                instr_buffer <= c_parcel;
            end
            br_pc[0]  <= pc_reg;
            br_pc[1]  <= br_pc[0];
            // the path not followed at fetch, used on a mismatch
            br_alt[0] <= predict_taken ? pc_seq : br_target;
            br_alt[1] <= br_alt[0];
        end
    end

    assign address           = (state == USE_BUFFER) ? pc_reg + 32'd2 : pc_reg;
    assign instruction_out   = instr;
    assign lookup_pc         = pc_reg;
    assign update_valid      = br_valid[1] && pc_write;
    assign update_pc         = br_pc[1];
    assign update_taken      = pc_src;
    assign decompress_failed = decompress_failed_in;

    a_state_known: assert property (@(posedge clk) disable iff (!reset_n)
        !$isunknown(state));

    a_flush_pair: assert property (@(posedge clk) disable iff (!reset_n)
        if_id_flush == id_ex_flush);

endmodule

`default_nettype wire

// File: verilog/branch_predictor.sv
`default_nettype none

module branch_predictor import fetch_pkg::*; #(
    parameter int PRED_ENTRIES = 64
) (
    input  logic       clk,
    input  logic       reset_n,
    input  pred_mode_t pred_mode,
    input  addr_t      lookup_pc,
    input  logic       update_valid,
    input  addr_t      update_pc,
    input  logic       update_taken,
    output logic       predict_taken
);

    localparam int IDX_W = $clog2(PRED_ENTRIES);
    localparam logic [1:0] WEAK_NT = 2'b01;

    typedef logic [IDX_W-1:0] idx_t;

    logic [1:0] counters [PRED_ENTRIES];
    idx_t       lookup_idx;
    idx_t       update_idx;
    logic [1:0] cnt_cur;

    // halfword bit skipped, entries are per word
    assign lookup_idx = lookup_pc[IDX_W+1:2];
    assign update_idx = update_pc[IDX_W+1:2];
    assign cnt_cur    = counters[update_idx];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < PRED_ENTRIES; i++) begin
                counters[i] <= WEAK_NT;
            end
        end else if (update_valid) begin
            // saturating two-bit counter
            if (update_taken && cnt_cur != 2'b11) begin
                counters[update_idx] <= cnt_cur + 2'd1;
            end else if (!update_taken && cnt_cur != 2'b00) begin
                counters[update_idx] <= cnt_cur - 2'd1;
            end
        end
    end

    assign predict_taken = (pred_mode == PRED_DYNAMIC) && counters[lookup_idx][1];

    a_update_pc_known: assert property (@(posedge clk) disable iff (!reset_n)
        update_valid |-> !$isunknown(update_pc));

endmodule

`default_nettype wire

// File: verilog/predictor_config.sv
`default_nettype none

module predictor_config import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        cfg_write,
    input  logic [31:0] cfg_wdata,
    output pred_mode_t  pred_mode
);

    // bit 0 selects dynamic prediction
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pred_mode <= PRED_STATIC_NT;
        end else if (cfg_write) begin
            pred_mode <= cfg_wdata[0] ? PRED_DYNAMIC : PRED_STATIC_NT;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
`default_nettype none

module fetch_top import fetch_pkg::*; #(
    parameter int    PRED_ENTRIES = 64,
    parameter addr_t RESET_PC     = '0
) (
    input  logic        clk,
    input  logic        reset_n,
    output addr_t       address,
    input  instr_t      data,
    input  logic        pc_write,
    input  logic        pc_src,
    input  logic        jalr_flag,
    input  addr_t       jalr_target,
    output instr_t      instruction_out,
    output logic        if_id_flush,
    output logic        id_ex_flush,
    output logic        decompress_failed,
    input  logic        cfg_write,
    input  logic [31:0] cfg_wdata
);

    addr_t      lookup_pc;
    logic       predict_taken;
    logic       update_valid;
    addr_t      update_pc;
    logic       update_taken;
    pred_mode_t pred_mode;
    half_t      c_parcel;
    logic       is_compressed;
    instr_t     decompressed_instr;
    logic       dec_failed;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk                  (clk),
        .reset_n              (reset_n),
        .data                 (data),
        .pc_write             (pc_write),
        .pc_src               (pc_src),
        .jalr_flag            (jalr_flag),
        .jalr_target          (jalr_target),
        .predict_taken        (predict_taken),
        .decompressed_instr   (decompressed_instr),
        .decompress_failed_in (dec_failed),
        .address              (address),
        .instruction_out      (instruction_out),
        .if_id_flush          (if_id_flush),
        .id_ex_flush          (id_ex_flush),
        .lookup_pc            (lookup_pc),
        .update_valid         (update_valid),
        .update_pc            (update_pc),
        .update_taken         (update_taken),
        .c_parcel             (c_parcel),
        .is_compressed        (is_compressed),
        .decompress_failed    (decompress_failed)
    );

    instr_decompressor u_decomp (
        .c_parcel           (c_parcel),
        .is_compressed      (is_compressed),
        .decompressed_instr (decompressed_instr),
        .decompress_failed  (dec_failed)
    );

    branch_predictor #(
        .PRED_ENTRIES (PRED_ENTRIES)
    ) u_bp (
        .clk           (clk),
        .reset_n       (reset_n),
        .pred_mode     (pred_mode),
        .lookup_pc     (lookup_pc),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .predict_taken (predict_taken)
    );

    predictor_config u_cfg (
        .clk       (clk),
        .reset_n   (reset_n),
        .cfg_write (cfg_write),
        .cfg_wdata (cfg_wdata),
        .pred_mode (pred_mode)
    );

endmodule

`default_nettype wire

// File: sim/tb_fetch_top.sv
`default_nettype none

module tb_fetch_top import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam addr_t RESET_PC      = 32'h0;
    localparam int    RESET_TIMEOUT = 40;
    localparam int    MEM_WORDS     = 64;

    // RV32I words placed in memory
    localparam instr_t I_ADDI_X1  = 32'h0050_0093;
    localparam instr_t I_ADDI_X2  = 32'h0070_0113;
    localparam instr_t I_ADD_X3   = 32'h0020_81B3;
    localparam instr_t I_ADDI_X4  = 32'h1230_0213;
    localparam instr_t I_BEQ_FWD  = 32'h0000_0863;
    localparam instr_t I_ADDI_X5  = 32'h0010_0293;
    localparam instr_t I_ADDI_X6  = 32'h0020_0313;
    localparam instr_t I_JALR     = 32'h0000_8067;
    localparam instr_t I_ADDI_X7  = 32'h0030_0393;
    localparam instr_t I_ADDI_X8  = 32'h0040_0413;
    localparam instr_t I_ADDI_X9  = 32'h0010_0493;
    localparam instr_t I_BEQ_BACK = 32'hFE00_0EE3;
    localparam instr_t I_ADDI_X10 = 32'h0090_0513;
    localparam instr_t NOP_WORD   = 32'h0000_0013;

    // words built from 16-bit parcels
    localparam instr_t W_COMP_PAIR = 32'h157D_4515;
    localparam instr_t W_SPLIT_LO  = 32'h0213_0000;
    localparam instr_t W_SPLIT_HI  = 32'h85AA_1230;

    // expected expansions of the compressed parcels
    localparam instr_t X_LI_X10   = 32'h0050_0513;
    localparam instr_t X_ADDI_M1  = 32'hFFF5_0513;
    localparam instr_t X_MV_X11   = 32'h00A0_05B3;
    localparam instr_t X_END_WORD = 32'hFE41_0113;

    logic        clk;
    logic        reset_n;
    addr_t       address;
    instr_t      data;
    logic        pc_write;
    logic        pc_src;
    logic        jalr_flag;
    addr_t       jalr_target;
    instr_t      instruction_out;
    logic        if_id_flush;
    logic        id_ex_flush;
    logic        decompress_failed;
    logic        cfg_write;
    logic [31:0] cfg_wdata;

    instr_t mem [MEM_WORDS];
    int     fail_count;
    int     cur_row;

    // one column per queue
    logic        row_pc_write    [$];
    logic        row_pc_src      [$];
    logic        row_jalr_flag   [$];
    addr_t       row_jalr_target [$];
    logic        row_cfg_write   [$];
    logic [31:0] row_cfg_wdata   [$];
    addr_t       row_address     [$];
    instr_t      row_instr       [$];
    logic        row_flush       [$];
    logic        row_failed      [$];

    fetch_top #(
        .PRED_ENTRIES (64),
        .RESET_PC     (RESET_PC)
    ) DUT (
        .clk               (clk),
        .reset_n           (reset_n),
        .address           (address),
        .data              (data),
        .pc_write          (pc_write),
        .pc_src            (pc_src),
        .jalr_flag         (jalr_flag),
        .jalr_target       (jalr_target),
        .instruction_out   (instruction_out),
        .if_id_flush       (if_id_flush),
        .id_ex_flush       (id_ex_flush),
        .decompress_failed (decompress_failed),
        .cfg_write         (cfg_write),
        .cfg_wdata         (cfg_wdata)
    );

    // same-cycle word read, aligned down
    assign data = mem[address[7:2]];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (16) @(posedge clk);
        #2 reset_n = 1'b1;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        lfsr_next = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic stop_with_failure;
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_count++;
            $display("Mismatch %s: got 0x%h, expected 0x%h at row %0d",
                     name, actual, expected, cur_row);
            stop_with_failure();
        end
    endtask

    // padding words, one lfsr step per bit
    task automatic fill_memory;
        logic [15:0] lfsr;
        logic [31:0] word;
        lfsr = 16'd35;
        for (int i = 0; i < MEM_WORDS; i++) begin
            for (int b = 0; b < 32; b++) begin
                lfsr    = lfsr_next(lfsr);
                word[b] = lfsr[0];
            end
            mem[i] = word ^ (32'(i) << 2);
        end
    endtask

    task automatic load_program;
        mem[0]  = I_ADDI_X1;
        mem[1]  = I_ADDI_X2;
        mem[2]  = I_ADD_X3;
        mem[3]  = W_COMP_PAIR;
        mem[4]  = W_SPLIT_LO;
        mem[5]  = W_SPLIT_HI;
        mem[6]  = I_BEQ_FWD;
        mem[7]  = I_ADDI_X5;
        mem[8]  = I_ADDI_X6;
        mem[10] = I_JALR;
        mem[11] = I_ADDI_X7;
        mem[12] = I_ADDI_X8;
        // loop body for the dynamic predictor
        mem[16] = I_ADDI_X9;
        mem[17] = I_BEQ_BACK;
        mem[18] = I_ADDI_X10;
        mem[19] = END_INSTR;
    endtask

    task automatic add_row(input logic wr, input logic src, input logic jalr,
                           input addr_t target, input logic cfg, input logic [31:0] wdata,
                           input addr_t exp_addr, input instr_t exp_instr,
                           input logic exp_flush, input logic exp_failed);
        row_pc_write.push_back(wr);
        row_pc_src.push_back(src);
        row_jalr_flag.push_back(jalr);
        row_jalr_target.push_back(target);
        row_cfg_write.push_back(cfg);
        row_cfg_wdata.push_back(wdata);
        row_address.push_back(exp_addr);
        row_instr.push_back(exp_instr);
        row_flush.push_back(exp_flush);
        row_failed.push_back(exp_failed);
    endtask

    task automatic build_table;
        // reset state, aligned words and one stall cycle
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h00, I_ADDI_X1, 0, 0);
        add_row(0, 0, 0, 32'h0, 0, 32'h0, 32'h04, I_ADDI_X2, 0, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h04, I_ADDI_X2, 0, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h08, I_ADD_X3, 0, 0);
        // c.li, c.addi, then the all-zero parcel
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h0C, X_LI_X10, 0, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h0E, X_ADDI_M1, 0, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h10, 32'h0, 0, 1);
        // split word, buffered cycle shows pc + 2
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h12, NOP_WORD, 0, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h14, I_ADDI_X4, 0, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h16, X_MV_X11, 0, 0);
        // static not taken, resolved taken two cycles later
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h18, I_BEQ_FWD, 0, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h1C, I_ADDI_X5, 0, 0);
        add_row(1, 1, 0, 32'h0, 0, 32'h0, 32'h20, I_ADDI_X6, 1, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h28, I_JALR, 0, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h2C, I_ADDI_X7, 0, 0);
        add_row(1, 0, 1, 32'h40, 0, 32'h0, 32'h30, I_ADDI_X8, 1, 0);
        // switch to dynamic mode
        add_row(1, 0, 0, 32'h0, 1, 32'h1, 32'h40, I_ADDI_X9, 0, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h44, I_BEQ_BACK, 0, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h48, I_ADDI_X10, 0, 0);
        add_row(1, 1, 0, 32'h0, 0, 32'h0, 32'h4C, X_END_WORD, 1, 0);
        // counter now weakly taken, branch jumps at fetch
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h40, I_ADDI_X9, 0, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h44, I_BEQ_BACK, 0, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h40, I_ADDI_X9, 0, 0);
        add_row(1, 1, 0, 32'h0, 0, 32'h0, 32'h44, I_BEQ_BACK, 0, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h40, I_ADDI_X9, 0, 0);
        add_row(1, 1, 0, 32'h0, 0, 32'h0, 32'h44, I_BEQ_BACK, 0, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h40, I_ADDI_X9, 0, 0);
        // loop exit, resolved not taken, then the halt word
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h44, I_BEQ_BACK, 1, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h48, I_ADDI_X10, 0, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h4C, X_END_WORD, 0, 0);
        add_row(1, 0, 0, 32'h0, 0, 32'h0, 32'h00, I_ADDI_X1, 0, 0);
    endtask

    task automatic wait_reset_release;
        int cycles;
        cycles = 0;
        while (reset_n !== 1'b1) begin
            if (cycles >= RESET_TIMEOUT) begin
                $display("reset_n was never released");
                stop_with_failure();
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    task automatic apply_row(input int r);
        cur_row = r;
        #2;
        pc_write    = row_pc_write[r];
        pc_src      = row_pc_src[r];
        jalr_flag   = row_jalr_flag[r];
        jalr_target = row_jalr_target[r];
        cfg_write   = row_cfg_write[r];
        cfg_wdata   = row_cfg_wdata[r];
        // late in the cycle, memory data has settled
        #34;
        check_value("address", address, row_address[r]);
        check_value("instruction_out", instruction_out, row_instr[r]);
        check_value("if_id_flush", 32'(if_id_flush), 32'(row_flush[r]));
        check_value("id_ex_flush", 32'(id_ex_flush), 32'(row_flush[r]));
        check_value("decompress_failed", 32'(decompress_failed), 32'(row_failed[r]));
        @(posedge clk);
    endtask

    initial begin
        fail_count  = 0;
        cur_row     = 0;
        pc_write    = 1'b0;
        pc_src      = 1'b0;
        jalr_flag   = 1'b0;
        jalr_target = '0;
        cfg_write   = 1'b0;
        cfg_wdata   = '0;
        fill_memory();
        load_program();
        build_table();
        wait_reset_release();
        for (int r = 0; r < row_address.size(); r++) begin
            apply_row(r);
        end
        if (fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

// File: all.f
verilog/fetch_pkg.sv
verilog/instr_decompressor.sv
verilog/fetch_stage.sv
verilog/branch_predictor.sv
verilog/predictor_config.sv
verilog/fetch_top.sv
sim/tb_fetch_top.sv

// File: Bender.yml
package:
  name: rv32ic_fetch

sources:
  - verilog/fetch_pkg.sv
  - verilog/instr_decompressor.sv
  - verilog/fetch_stage.sv
  - verilog/branch_predictor.sv
  - verilog/predictor_config.sv
  - verilog/fetch_top.sv
  - target: simulation
    files:
      - sim/tb_fetch_top.sv
